/* src/ing_cfg_pkg.sv */
// Ingress merge sizing
// Port count, bus width and per-port buffer geometry with their scalar types
`default_nettype none

package ing_cfg_pkg;

    localparam int NUM_PORTS          = 4;
    localparam int PORT_W             = 2;
    localparam int DATA_BYTES         = 8;
    localparam int DATA_W             = DATA_BYTES * 8;

    // Per-port data region and attribute region
    localparam int BUF_DEPTH_PER_PORT = 16;
    localparam int PTR_W              = 4;
    localparam int PKTS_PER_PORT      = 8;
    localparam int APTR_W             = 3;

    typedef logic [PORT_W-1:0]     port_idx_t;
    typedef logic [DATA_W-1:0]     data_t;
    typedef logic [DATA_BYTES-1:0] keep_t;
    typedef logic [PTR_W-1:0]      ptr_t;
    typedef logic [APTR_W-1:0]     aptr_t;

endpackage

`default_nettype wire

/* src/ing_atr_pkg.sv */
// Ingress attribute entry
// One entry per stored packet holding its last-word pointer and byte keep
`default_nettype none

package ing_atr_pkg;

    localparam int ATR_PTR_W  = ing_cfg_pkg::PTR_W;
    localparam int ATR_KEEP_W = ing_cfg_pkg::DATA_BYTES;
    localparam int ATR_W      = ATR_PTR_W + ATR_KEEP_W;

    // Raw word as kept in memory, field view for build and decode
    typedef union packed {
        logic [ATR_W-1:0] raw;
        struct packed {
            ing_cfg_pkg::ptr_t  last_ptr;
            ing_cfg_pkg::keep_t last_keep;
        } fld;
    } atr_entry_u;

endpackage

`default_nettype wire

/* src/ing_ptr_bank.sv */
// Ingress pointer bank
// Rotating write slot plus per-port data and attribute pointers with full/empty status
`timescale 1ns/1ps
`default_nettype none

module ing_ptr_bank (
    input  wire logic                                ing_bus,
    input  wire logic                                arst_n,
    input  wire logic [ing_cfg_pkg::NUM_PORTS-1:0]   in_valid,
    input  wire logic [ing_cfg_pkg::NUM_PORTS-1:0]   in_last,
    input  wire ing_cfg_pkg::port_idx_t              rd_sel,
    input  wire logic                                rd_adv,
    input  wire logic                                atr_pop,
    output logic      [ing_cfg_pkg::NUM_PORTS-1:0]   in_ready,
    output logic                                     wr_en,
    output logic                                     wr_last,
    output ing_cfg_pkg::port_idx_t                   wr_sel,
    output ing_cfg_pkg::ptr_t                        wr_ptr,
    output ing_cfg_pkg::aptr_t                       awr_ptr,
    output ing_cfg_pkg::ptr_t                        rd_ptr,
    output ing_cfg_pkg::aptr_t                       ard_ptr,
    output logic                                     pkt_avail
);

    import ing_cfg_pkg::*;

    // Pointers carry one extra wrap bit
    logic [PTR_W:0]  dwp [NUM_PORTS];
    logic [PTR_W:0]  drp [NUM_PORTS];
    logic [APTR_W:0] awp [NUM_PORTS];
    logic [APTR_W:0] arp [NUM_PORTS];

    logic [NUM_PORTS-1:0] d_full;
    logic [NUM_PORTS-1:0] d_empty;
    logic [NUM_PORTS-1:0] a_full;
    logic [NUM_PORTS-1:0] a_empty;

    // Slot rotation starts one cycle after reset release
    logic wr_run;

    ////////////////////////////////////////
    // Write slot rotation

    always_ff @(posedge ing_bus or negedge arst_n) begin
        if (!arst_n) begin
            wr_sel <= '0;
            wr_run <= 1'b0;
        end else begin
            wr_run <= 1'b1;
            if (wr_sel == port_idx_t'(NUM_PORTS - 1)) begin
                wr_sel <= '0;
            end else begin
                wr_sel <= wr_sel + 1'b1;
            end
        end
    end

    // At most one port is ready, so the OR picks the slot owner
    assign wr_en   = |(in_valid & in_ready);
    assign wr_last = in_last[wr_sel];
    assign wr_ptr  = dwp[wr_sel][PTR_W-1:0];
    assign awr_ptr = awp[wr_sel][APTR_W-1:0];

    ////////////////////////////////////////
    // Per-port pointers

    for (genvar p = 0; p < NUM_PORTS; p++) begin : g_port
        assign d_full[p]  = (dwp[p][PTR_W] != drp[p][PTR_W]) &&
                            (dwp[p][PTR_W-1:0] == drp[p][PTR_W-1:0]);
        assign d_empty[p] = (dwp[p] == drp[p]);
        assign a_full[p]  = (awp[p][APTR_W] != arp[p][APTR_W]) &&
                            (awp[p][APTR_W-1:0] == arp[p][APTR_W-1:0]);
        assign a_empty[p] = (awp[p] == arp[p]);

        assign in_ready[p] = wr_run && (wr_sel == port_idx_t'(p)) && !d_full[p] && !a_full[p];

        always_ff @(posedge ing_bus or negedge arst_n) begin
            if (!arst_n) begin
                dwp[p] <= '0;
                drp[p] <= '0;
                awp[p] <= '0;
                arp[p] <= '0;
            end else begin
                if (wr_en && wr_sel == port_idx_t'(p)) begin
                    dwp[p] <= dwp[p] + 1'b1;
                    // Attribute slot closes on the last word
                    if (wr_last) begin
                        awp[p] <= awp[p] + 1'b1;
                    end
                end
                if (rd_adv && rd_sel == port_idx_t'(p)) begin
                    drp[p] <= drp[p] + 1'b1;
                end
                if (atr_pop && rd_sel == port_idx_t'(p)) begin
                    arp[p] <= arp[p] + 1'b1;
                end
            end
        end
    end

    ////////////////////////////////////////
    // Read side addressing

    assign rd_ptr    = drp[rd_sel][PTR_W-1:0];
    assign ard_ptr   = arp[rd_sel][APTR_W-1:0];
    assign pkt_avail = !a_empty[rd_sel];

    a_ready_onehot : assert property (
        @(posedge ing_bus) disable iff (!arst_n)
        $onehot0(in_ready)
    );

    // Scheduler must only pull words that were written
    a_adv_not_empty : assert property (
        @(posedge ing_bus) disable iff (!arst_n)
        rd_adv |-> !d_empty[rd_sel]
    );

endmodule

`default_nettype wire

/* src/ing_pkt_buf.sv */
// Ingress packet buffer
// Shared data memory split into one region per port, combinational read
`timescale 1ns/1ps
`default_nettype none

module ing_pkt_buf (
    input  wire logic                    ing_bus,
    input  wire ing_cfg_pkg::data_t      in_data [ing_cfg_pkg::NUM_PORTS],
    input  wire logic                    wr_en,
    input  wire ing_cfg_pkg::port_idx_t  wr_sel,
    input  wire ing_cfg_pkg::ptr_t       wr_ptr,
    input  wire ing_cfg_pkg::port_idx_t  rd_sel,
    input  wire ing_cfg_pkg::ptr_t       rd_ptr,
    output ing_cfg_pkg::data_t           rd_data
);

    import ing_cfg_pkg::*;

    // Port index is the upper address part
    data_t mem [NUM_PORTS * BUF_DEPTH_PER_PORT];

    logic [PORT_W+PTR_W-1:0] wr_addr;
    logic [PORT_W+PTR_W-1:0] rd_addr;

    assign wr_addr = {wr_sel, wr_ptr};
    assign rd_addr = {rd_sel, rd_ptr};

    always_ff @(posedge ing_bus) begin
        if (wr_en) begin
            mem[wr_addr] <= in_data[wr_sel];
        end
    end

    assign rd_data = mem[rd_addr];

endmodule

`default_nettype wire

/* src/ing_atr_buf.sv */
// Ingress attribute buffer
// Stores last-word pointer and keep for each complete packet, per port region
`timescale 1ns/1ps
`default_nettype none

module ing_atr_buf (
    input  wire logic                    ing_bus,
    input  wire ing_cfg_pkg::keep_t      in_keep [ing_cfg_pkg::NUM_PORTS],
    input  wire logic                    wr_last,
    input  wire logic                    wr_en,
    input  wire ing_cfg_pkg::port_idx_t  wr_sel,
    input  wire ing_cfg_pkg::ptr_t       wr_ptr,
    input  wire ing_cfg_pkg::aptr_t      awr_ptr,
    input  wire ing_cfg_pkg::port_idx_t  rd_sel,
    input  wire ing_cfg_pkg::aptr_t      ard_ptr,
    output ing_atr_pkg::atr_entry_u      rd_atr
);

    import ing_cfg_pkg::*;
    import ing_atr_pkg::*;

    logic [ATR_W-1:0] mem [NUM_PORTS * PKTS_PER_PORT];

    atr_entry_u wr_entry;

    // Entry for the word being written
    always_comb begin
        wr_entry.fld.last_ptr  = wr_ptr;
        wr_entry.fld.last_keep = in_keep[wr_sel];
    end

    always_ff @(posedge ing_bus) begin
        if (wr_en && wr_last) begin
            mem[{wr_sel, awr_ptr}] <= wr_entry.raw;
        end
    end

    assign rd_atr = atr_entry_u'(mem[{rd_sel, ard_ptr}]);

endmodule

`default_nettype wire

/* src/ing_rd_fsm.sv */
// Ingress read scheduler
// Round-robin packet readout onto the merged output with a registered stage
`timescale 1ns/1ps
`default_nettype none

module ing_rd_fsm (
    input  wire logic                    ing_bus,
    input  wire logic                    arst_n,
    input  wire logic                    pkt_avail,
    input  wire ing_cfg_pkg::ptr_t       rd_ptr,
    input  wire ing_cfg_pkg::data_t      rd_data,
    input  wire ing_atr_pkg::atr_entry_u rd_atr,
    input  wire logic                    out_ready,
    output ing_cfg_pkg::port_idx_t       rd_sel,
    output logic                         rd_adv,
    output logic                         atr_pop,
    output logic                         out_valid,
    output ing_cfg_pkg::data_t           out_data,
    output ing_cfg_pkg::keep_t           out_keep,
    output logic                         out_last,
    output ing_cfg_pkg::port_idx_t       out_user
);

    import ing_cfg_pkg::*;

    // Low is SCAN, high is SEND
    logic st_send;

    logic load;
    logic is_last;
    port_idx_t next_sel;

    // Output register free or being emptied this cycle
    assign load    = st_send && (!out_valid || out_ready);
    assign is_last = (rd_ptr == rd_atr.fld.last_ptr);

    assign rd_adv  = load;
    assign atr_pop = load && is_last;

    assign next_sel = (rd_sel == port_idx_t'(NUM_PORTS - 1)) ? '0 : rd_sel + 1'b1;

    ////////////////////////////////////////
    // Scheduler state

    always_ff @(posedge ing_bus or negedge arst_n) begin
        if (!arst_n) begin
            st_send <= 1'b0;
            rd_sel  <= '0;
        end else if (!st_send) begin
            if (pkt_avail) begin
                st_send <= 1'b1;
            end else begin
                rd_sel <= next_sel;
            end
        end else if (load && is_last) begin
            // Packet done, resume scan past this port
            st_send <= 1'b0;
            rd_sel  <= next_sel;
        end
    end

    ////////////////////////////////////////
    // Output stage

    always_ff @(posedge ing_bus or negedge arst_n) begin
        if (!arst_n) begin
            out_valid <= 1'b0;
            out_last  <= 1'b0;
        end else if (load) begin
            out_valid <= 1'b1;
            out_last  <= is_last;
        end else if (out_ready) begin
            out_valid <= 1'b0;
            out_last  <= 1'b0;
        end
    end

    always_ff @(posedge ing_bus) begin
        if (load) begin
            out_data <= rd_data;
            out_keep <= is_last ? rd_atr.fld.last_keep : '1;
            out_user <= rd_sel;
        end
    end

    a_out_hold : assert property (
        @(posedge ing_bus) disable iff (!arst_n)
        out_valid && !out_ready |=> out_valid && $stable(out_data) && $stable(out_keep)
            && $stable(out_last) && $stable(out_user)
    );

endmodule

`default_nettype wire

/* src/ing_merge_top.sv */
// Ingress merge stage
// Per-port streams into one shared buffer, read out round-robin by packet
`timescale 1ns/1ps
`default_nettype none

module ing_merge_top (
    input  wire logic                               ing_bus,
    input  wire logic                               arst_n,
    input  wire logic [ing_cfg_pkg::NUM_PORTS-1:0]  in_valid,
    output logic      [ing_cfg_pkg::NUM_PORTS-1:0]  in_ready,
    input  wire ing_cfg_pkg::data_t                 in_data [ing_cfg_pkg::NUM_PORTS],
    input  wire ing_cfg_pkg::keep_t                 in_keep [ing_cfg_pkg::NUM_PORTS],
    input  wire logic [ing_cfg_pkg::NUM_PORTS-1:0]  in_last,
    output logic                                    out_valid,
    input  wire logic                               out_ready,
    output ing_cfg_pkg::data_t                      out_data,
    output ing_cfg_pkg::keep_t                      out_keep,
    output logic                                    out_last,
    output ing_cfg_pkg::port_idx_t                  out_user
);

    import ing_cfg_pkg::*;
    import ing_atr_pkg::*;

    // Write side
    logic      wr_en;
    logic      wr_last;
    port_idx_t wr_sel;
    ptr_t      wr_ptr;
    aptr_t     awr_ptr;

    // Read side
    port_idx_t  rd_sel;
    ptr_t       rd_ptr;
    aptr_t      ard_ptr;
    logic       pkt_avail;
    logic       rd_adv;
    logic       atr_pop;
    data_t      rd_data;
    atr_entry_u rd_atr;

    ing_ptr_bank u_ptr_bank (
        .ing_bus   (ing_bus),
        .arst_n    (arst_n),
        .in_valid  (in_valid),
        .in_last   (in_last),
        .rd_sel    (rd_sel),
        .rd_adv    (rd_adv),
        .atr_pop   (atr_pop),
        .in_ready  (in_ready),
        .wr_en     (wr_en),
        .wr_last   (wr_last),
        .wr_sel    (wr_sel),
        .wr_ptr    (wr_ptr),
        .awr_ptr   (awr_ptr),
        .rd_ptr    (rd_ptr),
        .ard_ptr   (ard_ptr),
        .pkt_avail (pkt_avail)
    );

    ing_pkt_buf u_pkt_buf (
        .ing_bus (ing_bus),
        .in_data (in_data),
        .wr_en   (wr_en),
        .wr_sel  (wr_sel),
        .wr_ptr  (wr_ptr),
        .rd_sel  (rd_sel),
        .rd_ptr  (rd_ptr),
        .rd_data (rd_data)
    );

    ing_atr_buf u_atr_buf (
        .ing_bus (ing_bus),
        .in_keep (in_keep),
        .wr_last (wr_last),
        .wr_en   (wr_en),
        .wr_sel  (wr_sel),
        .wr_ptr  (wr_ptr),
        .awr_ptr (awr_ptr),
        .rd_sel  (rd_sel),
        .ard_ptr (ard_ptr),
        .rd_atr  (rd_atr)
    );

    ing_rd_fsm u_rd_fsm (
        .ing_bus   (ing_bus),
        .arst_n    (arst_n),
        .pkt_avail (pkt_avail),
        .rd_ptr    (rd_ptr),
        .rd_data   (rd_data),
        .rd_atr    (rd_atr),
        .out_ready (out_ready),
        .rd_sel    (rd_sel),
        .rd_adv    (rd_adv),
        .atr_pop   (atr_pop),
        .out_valid (out_valid),
        .out_data  (out_data),
        .out_keep  (out_keep),
        .out_last  (out_last),
        .out_user  (out_user)
    );

endmodule

`default_nettype wire

/* test/tb_ing_merge.sv */
// Ingress merge testbench
// Table-driven port traffic checked against per-port scoreboards on the merged output
`timescale 1ns/1ps
`default_nettype none

module tb_ing_merge;

    import ing_cfg_pkg::*;

    typedef struct packed {
        int    test;
        int    port;
        int    len;
        keep_t keep;
        int    mode;
    } row_t;

    localparam int N_ROWS   = 23;
    localparam int HOLD_CYC = 160;
    // out_ready modes
    localparam int RDY_ON   = 0;
    localparam int RDY_RAND = 1;
    localparam int RDY_HOLD = 2;

    logic                 ing_bus;
    logic                 arst_n;
    logic [NUM_PORTS-1:0] in_valid;
    logic [NUM_PORTS-1:0] in_ready;
    data_t                in_data [NUM_PORTS];
    keep_t                in_keep [NUM_PORTS];
    logic [NUM_PORTS-1:0] in_last;
    logic                 out_valid;
    logic                 out_ready;
    data_t                out_data;
    keep_t                out_keep;
    logic                 out_last;
    port_idx_t            out_user;

    row_t rows [N_ROWS];
    // Expected words per port as {last, keep, data}
    logic [DATA_W+DATA_BYTES:0] exp_q [NUM_PORTS][$];

    int          pkt_num [NUM_PORTS];
    int          acc_cnt [NUM_PORTS];
    int          err_cnt;
    int          fail_tests;
    int          rx_words;
    int          cycle_cnt;
    int          cycle_limit;
    int          rdy_mode;
    logic [31:0] lfsr;

    // Monitor state
    logic                              held;
    logic                              in_pkt;
    port_idx_t                         pkt_user;
    logic [DATA_W+DATA_BYTES+PORT_W:0] hold_w;

    ing_merge_top u_dut (
        .ing_bus   (ing_bus),
        .arst_n    (arst_n),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_data   (in_data),
        .in_keep   (in_keep),
        .in_last   (in_last),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_data  (out_data),
        .out_keep  (out_keep),
        .out_last  (out_last),
        .out_user  (out_user)
    );

    initial ing_bus = 1'b0;
    always #4 ing_bus = ~ing_bus;

    ////////////////////////////////////////
    // Helpers

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'h8020_0003;
        end
        return s >> 1;
    endfunction

    // Port, packet number and word index in one word
    function automatic data_t make_word(input int p, input int pkt, input int idx);
        return {8'(p), 8'hA5, 16'(pkt), 16'(idx), 16'(pkt * 7 + idx)};
    endfunction

    function automatic int test_mode(input int t);
        for (int r = 0; r < N_ROWS; r++) begin
            if (rows[r].test == t) begin
                return rows[r].mode;
            end
        end
        return RDY_ON;
    endfunction

    function automatic int words_for(input int t, input int p);
        int n;
        n = 0;
        for (int r = 0; r < N_ROWS; r++) begin
            if ((t == 0 || rows[r].test == t) && (p < 0 || rows[r].port == p)) begin
                n += rows[r].len;
            end
        end
        return n;
    endfunction

    function automatic int pending_words();
        int n;
        n = 0;
        for (int p = 0; p < NUM_PORTS; p++) begin
            n += exp_q[p].size();
        end
        return n;
    endfunction

    function automatic string test_name(input int t);
        case (t)
            1:       return "reset state";
            2:       return "single-port packets";
            3:       return "round-robin merge";
            4:       return "output back-pressure";
            default: return "region full";
        endcase
    endfunction

    task automatic flag_error(input string msg);
        $display("[ERROR] %0t: %s", $time, msg);
        err_cnt++;
    endtask

    task automatic report_test(input int t, input int errs_before);
        if (err_cnt == errs_before) begin
            $display("Test %0d %s: ok", t, test_name(t));
        end else begin
            $display("Test %0d %s: %0d errors", t, test_name(t), err_cnt - errs_before);
            fail_tests++;
        end
    endtask

    ////////////////////////////////////////
    // Port driver and hold release

    // Called on a falling edge, returns on one
    task automatic drive_port(input int t, input int p);
        data_t w;
        keep_t k;
        logic  l;
        for (int r = 0; r < N_ROWS; r++) begin
            if (rows[r].test == t && rows[r].port == p) begin
                for (int i = 0; i < rows[r].len; i++) begin
                    w = make_word(p, pkt_num[p], i);
                    l = (i == rows[r].len - 1);
                    k = l ? rows[r].keep : '1;
                    exp_q[p].push_back({l, k, w});
                    in_valid[p] = 1'b1;
                    in_data[p]  = w;
                    in_keep[p]  = k;
                    in_last[p]  = l;
                    @(posedge ing_bus);
                    while (!in_ready[p]) begin
                        @(posedge ing_bus);
                    end
                    acc_cnt[p]++;
                    @(negedge ing_bus);
                end
                pkt_num[p]++;
            end
        end
        in_valid[p] = 1'b0;
        in_last[p]  = 1'b0;
    endtask

    // Under hold, port 1 starts only once port 0 has filled its region
    task automatic wait_region_fill(input int t);
        if (test_mode(t) != RDY_HOLD) begin
            return;
        end
        while (acc_cnt[0] < BUF_DEPTH_PER_PORT) begin
            @(negedge ing_bus);
        end
    endtask

    task automatic release_hold(input int t);
        int exp0;
        if (test_mode(t) != RDY_HOLD) begin
            return;
        end
        repeat (HOLD_CYC) @(negedge ing_bus);
        // First port 0 word waits in the output register and frees one slot
        exp0 = BUF_DEPTH_PER_PORT + 1;
        if (acc_cnt[0] != exp0) begin
            flag_error($sformatf("port 0 accepted %0d words while held, expected %0d",
                acc_cnt[0], exp0));
        end
        if (acc_cnt[1] != words_for(t, 1)) begin
            flag_error($sformatf("port 1 accepted %0d words while port 0 full, expected %0d",
                acc_cnt[1], words_for(t, 1)));
        end
        @(posedge ing_bus);
        rdy_mode = RDY_ON;
    endtask

    always @(negedge ing_bus) begin
        case (rdy_mode)
            RDY_RAND: begin
                lfsr      = lfsr_next(lfsr);
                out_ready = lfsr[0];
            end
            RDY_HOLD: out_ready = 1'b0;
            default:  out_ready = 1'b1;
        endcase
    end

    ////////////////////////////////////////
    // Output monitor and timeout

    always @(posedge ing_bus) begin
        logic [DATA_W+DATA_BYTES+PORT_W:0] cur;
        logic [DATA_W+DATA_BYTES:0]        exp_w;
        cur = {out_last, out_user, out_keep, out_data};
        if (arst_n) begin
            if (held && (!out_valid || cur !== hold_w)) begin
                flag_error("output changed while stalled");
            end
            if (out_valid && out_ready) begin
                if (in_pkt && out_user != pkt_user) begin
                    flag_error($sformatf("port %0d word inside a port %0d packet",
                        out_user, pkt_user));
                end
                if (out_data[DATA_W-1 -: 8] != 8'(out_user)) begin
                    flag_error($sformatf("out_user %0d, data from port %0d",
                        out_user, out_data[DATA_W-1 -: 8]));
                end
                if (exp_q[out_user].size() == 0) begin
                    flag_error($sformatf("unexpected word on port %0d", out_user));
                end else begin
                    exp_w = exp_q[out_user].pop_front();
                    if ({out_last, out_keep, out_data} !== exp_w) begin
                        flag_error($sformatf("port %0d got %h/%h/%b, expected %h/%h/%b",
                            out_user, out_data, out_keep, out_last, exp_w[DATA_W-1:0],
                            exp_w[DATA_W +: DATA_BYTES], exp_w[DATA_W+DATA_BYTES]));
                    end
                end
                in_pkt   = !out_last;
                pkt_user = out_user;
                rx_words++;
            end
            held   = out_valid && !out_ready;
            hold_w = cur;
        end
    end

    always @(posedge ing_bus) begin
        cycle_cnt++;
        if (cycle_limit > 0 && cycle_cnt > cycle_limit) begin
            $display("Timeout: simulation ran past %0d cycles without finishing", cycle_limit);
            $display("TESTBENCH FAILED");
            $finish;
        end
    end

    ////////////////////////////////////////
    // Main sequence

    initial begin
        int errs_before;
        rows = '{
            '{2, 0, 1, 8'h01, RDY_ON},   '{2, 1, 5, 8'h0f, RDY_ON},   '{2, 2, 16, 8'hff, RDY_ON},
            '{3, 0, 3, 8'h07, RDY_ON},   '{3, 1, 7, 8'h3f, RDY_ON},   '{3, 2, 4, 8'h1f, RDY_ON},
            '{3, 3, 8, 8'h7f, RDY_ON},   '{3, 0, 6, 8'hff, RDY_ON},   '{3, 1, 2, 8'h01, RDY_ON},
            '{3, 2, 1, 8'h03, RDY_ON},   '{3, 3, 5, 8'h0f, RDY_ON},
            '{4, 0, 9, 8'hff, RDY_RAND}, '{4, 1, 4, 8'h03, RDY_RAND}, '{4, 2, 12, 8'h7f, RDY_RAND},
            '{4, 3, 2, 8'h01, RDY_RAND}, '{4, 0, 3, 8'h0f, RDY_RAND}, '{4, 3, 6, 8'h3f, RDY_RAND},
            '{5, 0, 8, 8'hff, RDY_HOLD}, '{5, 0, 8, 8'h0f, RDY_HOLD}, '{5, 0, 6, 8'h03, RDY_HOLD},
            '{5, 1, 5, 8'h1f, RDY_HOLD}, '{5, 1, 5, 8'h07, RDY_HOLD}, '{5, 1, 5, 8'hff, RDY_HOLD}
        };
        arst_n    = 1'b0;
        in_valid  = '0;
        in_last   = '0;
        out_ready = 1'b0;
        for (int p = 0; p < NUM_PORTS; p++) begin
            in_data[p] = '0;
            in_keep[p] = '0;
            pkt_num[p] = 0;
            acc_cnt[p] = 0;
        end
        err_cnt     = 0;
        fail_tests  = 0;
        rx_words    = 0;
        cycle_cnt   = 0;
        rdy_mode    = RDY_ON;
        lfsr        = 32'h5888;
        held        = 1'b0;
        in_pkt      = 1'b0;
        pkt_user    = '0;
        cycle_limit = words_for(0, -1) * NUM_PORTS * 4 + 200;

        // Nothing may come out before a packet is written
        repeat (2) begin
            @(negedge ing_bus);
            if (out_valid !== 1'b0 || in_ready !== '0) begin
                flag_error("out_valid or in_ready high during reset");
            end
        end
        arst_n = 1'b1;
        repeat (6) begin
            @(negedge ing_bus);
            if (out_valid !== 1'b0) begin
                flag_error("out_valid high with no packet written");
            end
        end
        report_test(1, 0);

        for (int t = 2; t <= 5; t++) begin
            errs_before = err_cnt;
            for (int p = 0; p < NUM_PORTS; p++) begin
                acc_cnt[p] = 0;
            end
            @(posedge ing_bus);
            rdy_mode = test_mode(t);
            @(negedge ing_bus);
            fork
                drive_port(t, 0);
                begin
                    wait_region_fill(t);
                    drive_port(t, 1);
                end
                drive_port(t, 2);
                drive_port(t, 3);
                release_hold(t);
            join
            while (pending_words() != 0) begin
                @(negedge ing_bus);
            end
            repeat (8) @(negedge ing_bus);
            report_test(t, errs_before);
        end

        $display("Summary: 5 tests, %0d failed, %0d words checked, %0d errors",
            fail_tests, rx_words, err_cnt);
        if (err_cnt == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* list.f */
src/ing_cfg_pkg.sv
src/ing_atr_pkg.sv
src/ing_ptr_bank.sv
src/ing_pkt_buf.sv
src/ing_atr_buf.sv
src/ing_rd_fsm.sv
src/ing_merge_top.sv
test/tb_ing_merge.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the ingress merge testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timescale 1ns/1ps --top-module tb_ing_merge -f list.f \
    -o tb_ing_merge || { echo "Verilator build failed"; exit 1; }

./obj_dir/tb_ing_merge > sim.log 2>&1
cat sim.log
grep -q "TESTBENCH FAILED" sim.log && exit 1
grep -q "TESTBENCH PASSED" sim.log && exit 0 || { echo "No result in sim.log"; exit 1; }
